// File: hw/cpu_ctrl.sv
`timescale 1ns/1ps
`include "cpu_ctrl_settings.svh"

module cpu_ctrl (
	input  logic                      clk,
	input  logic                      reset,
	input  logic                      enable,
	input  logic                      z,
	input  logic [`CTRL_IR_WIDTH-1:0] ir,
	output cpu_ctrl_pkg::ctrl_word_t  ctrl
);
	import cpu_ctrl_pkg::*;

	micro_state_t   state;
	decoded_instr_t instr;
	logic           taken;

	instr_decode u_decode (
		.clk   (clk),
		.reset (reset),
		.ir    (ir),
		.state (state),
		.instr (instr)
	);

	micro_sequencer u_sequencer (
		.clk    (clk),
		.reset  (reset),
		.enable (enable),
		.z      (z),
		.instr  (instr),
		.state  (state),
		.taken  (taken)
	);

	// Word follows registered state only
	ctrl_word_gen u_ctrl_word (
		.state (state),
		.instr (instr),
		.taken (taken),
		.ctrl  (ctrl)
	);

endmodule

// File: hw/cpu_ctrl_pkg.sv
`include "cpu_ctrl_settings.svh"

package cpu_ctrl_pkg;

	////////////////////////////////////////////////////////////////////////////
	// Instruction side
	////////////////////////////////////////////////////////////////////////////

	// Opcode numbering of the instruction set
	typedef enum logic [`CTRL_OPCODE_WIDTH-1:0] {
		OP_END     = 5,
		OP_LDAC    = 6,
		OP_CLAC    = 8,
		OP_INCAC   = 9,
		OP_DECAC   = 10,
		OP_MVAC_DI = 11, OP_MVAC_RI = 12, OP_MVAC_BI = 13, OP_MVAC_S = 14,
		OP_MVAC_C1 = 15, OP_MVAC_C2 = 16, OP_MVAC_AR = 17,
		OP_MV_DI   = 18, OP_MV_RI   = 19, OP_MV_BI   = 20, OP_MV_S   = 21,
		OP_MV_C1   = 22, OP_MV_C2   = 23, OP_MV_AR   = 24,
		OP_READ    = 25,
		OP_WRITE   = 27,
		OP_ADD_DI  = 29, OP_ADD_RI  = 30, OP_ADD_BI  = 31, OP_ADD_S  = 32,
		OP_ADD_C1  = 33, OP_ADD_C2  = 34, OP_ADD_AR  = 35,
		OP_SUB_DI  = 36, OP_SUB_RI  = 37, OP_SUB_BI  = 38, OP_SUB_S  = 39,
		OP_SUB_C1  = 40, OP_SUB_C2  = 41, OP_SUB_AR  = 42,
		OP_MUL2    = 43,
		OP_MUL4    = 44,
		OP_DIV16   = 45,
		OP_JMPZ    = 46,
		OP_JMPNZ   = 49
	} opcode_t;

	typedef enum logic [`CTRL_CLASS_WIDTH-1:0] {
		CL_NOP,         // Any unknown opcode
		CL_END,
		CL_LDAC,
		CL_CLAC,
		CL_INCAC,
		CL_DECAC,
		CL_MV_TO_REG,   // Register <= AC
		CL_MV_FROM_REG, // AC <= register
		CL_READ,
		CL_WRITE,
		CL_ADD,
		CL_SUB,
		CL_MUL2,
		CL_MUL4,
		CL_DIV16,
		CL_JMPZ,
		CL_JMPNZ
	} instr_class_t;

	typedef enum logic [`CTRL_REG_ID_WIDTH-1:0] {
		REG_DI, REG_RI, REG_BI, REG_S, REG_C1, REG_C2, REG_AR
	} reg_id_t;

	typedef struct packed {
		instr_class_t cls;
		reg_id_t      reg_op; // Operand of moves, ADD and SUB
	} decoded_instr_t;

	typedef enum logic [`CTRL_STATE_WIDTH-1:0] {
		ST_IDLE,
		ST_FETCH1, ST_FETCH2, ST_FETCH3, ST_FETCH4,
		ST_EXEC1, ST_EXEC2, ST_EXEC3, ST_EXEC4,
		ST_HALT
	} micro_state_t;

	////////////////////////////////////////////////////////////////////////////
	// Control word
	////////////////////////////////////////////////////////////////////////////

	typedef enum logic [`CTRL_ALU_SEL_WIDTH-1:0] {
		ALU_CLEAR = 0, ALU_INC  = 1, ALU_DEC  = 2, ALU_ADD   = 3, ALU_SUB  = 4,
		ALU_MUL2  = 5, ALU_MUL4 = 6, ALU_DIV16 = 7, ALU_LOAD = 8, ALU_NOP = 9
	} alu_op_t;

	typedef enum logic [`CTRL_BUS_SEL_WIDTH-1:0] {
		BUS_DRAM = 0, BUS_IRAM = 1, BUS_DI = 2, BUS_RI  = 3,
		BUS_BI   = 4, BUS_S    = 5, BUS_C1 = 6, BUS_C2  = 7,
		BUS_AR   = 8, BUS_AC   = 9, BUS_PC = 10, BUS_IR = 11
	} bus_src_t;

	// One-hot loads, IR in bit 0 and PC in bit 8
	typedef enum logic [`CTRL_REG_SEL_WIDTH-1:0] {
		LOAD_NONE = 9'h000,
		LOAD_IR   = 9'h001,
		LOAD_DI   = 9'h002,
		LOAD_RI   = 9'h004,
		LOAD_BI   = 9'h008,
		LOAD_S    = 9'h010,
		LOAD_C1   = 9'h020,
		LOAD_C2   = 9'h040,
		LOAD_AR   = 9'h080,
		LOAD_PC   = 9'h100
	} reg_load_t;

	typedef struct packed {
		logic      pc_inc;
		logic      finish;
		logic      data_ram_we;
		alu_op_t   alu_sel;
		bus_src_t  bus_sel;
		reg_load_t reg_sel;
	} ctrl_word_t;

endpackage

// File: hw/cpu_ctrl_settings.svh
`ifndef CPU_CTRL_SETTINGS_SVH
`define CPU_CTRL_SETTINGS_SVH

////////////////////////////////////////////////////////////////////////////
// Instruction word
////////////////////////////////////////////////////////////////////////////

// Full instruction register
`define CTRL_IR_WIDTH 32
// Opcode field, low bits of IR
`define CTRL_OPCODE_WIDTH 8

////////////////////////////////////////////////////////////////////////////
// Control word fields
////////////////////////////////////////////////////////////////////////////

`define CTRL_ALU_SEL_WIDTH 4
`define CTRL_BUS_SEL_WIDTH 4
// One load bit per register, IR to PC
`define CTRL_REG_SEL_WIDTH 9

// Internal encodings
`define CTRL_CLASS_WIDTH 5
`define CTRL_REG_ID_WIDTH 3
`define CTRL_STATE_WIDTH 4

`endif

// File: hw/ctrl_word_gen.sv
`timescale 1ns/1ps

module ctrl_word_gen (
	input  cpu_ctrl_pkg::micro_state_t   state,
	input  cpu_ctrl_pkg::decoded_instr_t instr,
	input  logic                         taken,
	output cpu_ctrl_pkg::ctrl_word_t     ctrl
);
	import cpu_ctrl_pkg::*;

	// ALU idle, IRAM on the bus, nothing loaded
	localparam ctrl_word_t DEFAULT_WORD = '{
		pc_inc:      1'b0,
		finish:      1'b0,
		data_ram_we: 1'b0,
		alu_sel:     ALU_NOP,
		bus_sel:     BUS_IRAM,
		reg_sel:     LOAD_NONE
	};

	function automatic bus_src_t reg_bus(input reg_id_t r);
		case (r)
			REG_DI:  return BUS_DI;
			REG_RI:  return BUS_RI;
			REG_BI:  return BUS_BI;
			REG_S:   return BUS_S;
			REG_C1:  return BUS_C1;
			REG_C2:  return BUS_C2;
			REG_AR:  return BUS_AR;
			default: return BUS_IRAM;
		endcase
	endfunction

	function automatic reg_load_t reg_load(input reg_id_t r);
		case (r)
			REG_DI:  return LOAD_DI;
			REG_RI:  return LOAD_RI;
			REG_BI:  return LOAD_BI;
			REG_S:   return LOAD_S;
			REG_C1:  return LOAD_C1;
			REG_C2:  return LOAD_C2;
			REG_AR:  return LOAD_AR;
			default: return LOAD_NONE;
		endcase
	endfunction

	////////////////////////////////////////////////////////////////////////////
	// Control word per step
	////////////////////////////////////////////////////////////////////////////

	always_comb begin
		ctrl = DEFAULT_WORD;
		case (state)
			ST_FETCH2: ctrl.reg_sel = LOAD_IR; // IR <= IRAM
			ST_FETCH3: ctrl.pc_inc = 1'b1;
			ST_HALT:   ctrl.finish = 1'b1;
			ST_EXEC1: begin
				case (instr.cls)
					CL_CLAC:  ctrl.alu_sel = ALU_CLEAR;
					CL_INCAC: ctrl.alu_sel = ALU_INC;
					CL_DECAC: ctrl.alu_sel = ALU_DEC;
					CL_MUL2:  ctrl.alu_sel = ALU_MUL2;
					CL_MUL4:  ctrl.alu_sel = ALU_MUL4;
					CL_DIV16: ctrl.alu_sel = ALU_DIV16;
					CL_MV_TO_REG: begin // Register <= AC
						ctrl.bus_sel = BUS_AC;
						ctrl.reg_sel = reg_load(instr.reg_op);
					end
					CL_MV_FROM_REG: begin
						ctrl.bus_sel = reg_bus(instr.reg_op);
						ctrl.alu_sel = ALU_LOAD;
					end
					CL_ADD: begin
						ctrl.bus_sel = reg_bus(instr.reg_op);
						ctrl.alu_sel = ALU_ADD;
					end
					CL_SUB: begin
						ctrl.bus_sel = reg_bus(instr.reg_op);
						ctrl.alu_sel = ALU_SUB;
					end
					CL_READ:  ctrl.bus_sel = BUS_DRAM; // Address already in AR
					CL_WRITE: begin
						ctrl.bus_sel = BUS_AC;
						ctrl.data_ram_we = 1'b1;
					end
					// Step past the operand word
					CL_LDAC, CL_JMPZ, CL_JMPNZ: ctrl.pc_inc = 1'b1;
					default: ctrl = DEFAULT_WORD;
				endcase
			end
			ST_EXEC2: begin
				case (instr.cls)
					CL_LDAC: begin // AC <= immediate
						ctrl.alu_sel = ALU_LOAD;
						ctrl.bus_sel = BUS_IRAM;
					end
					CL_READ: begin
						ctrl.alu_sel = ALU_LOAD;
						ctrl.bus_sel = BUS_DRAM;
					end
					CL_WRITE: ctrl.bus_sel = BUS_DRAM; // Write settles
					default:  ctrl = DEFAULT_WORD;
				endcase
			end
			ST_EXEC3: begin
				if (taken)
					ctrl.reg_sel = LOAD_PC; // PC <= jump target
			end
			default: ctrl = DEFAULT_WORD;
		endcase
	end

endmodule

// File: hw/instr_decode.sv
`timescale 1ns/1ps
`include "cpu_ctrl_settings.svh"

module instr_decode (
	input  logic                         clk,
	input  logic                         reset,
	input  logic [`CTRL_IR_WIDTH-1:0]    ir,
	input  cpu_ctrl_pkg::micro_state_t   state,
	output cpu_ctrl_pkg::decoded_instr_t instr
);
	import cpu_ctrl_pkg::*;

	logic [`CTRL_OPCODE_WIDTH-1:0] op_code;
	decoded_instr_t                dec;  // Decode of the current IR
	decoded_instr_t                held; // Latched at the end of FETCH4

	// Register operand from the distance to the first code of a group
	function automatic reg_id_t reg_from(
		input logic [`CTRL_OPCODE_WIDTH-1:0] code,
		input opcode_t                       base
	);
		logic [`CTRL_OPCODE_WIDTH-1:0] offs;
		offs = code - base;
		return reg_id_t'(offs[`CTRL_REG_ID_WIDTH-1:0]);
	endfunction

	assign op_code = ir[`CTRL_OPCODE_WIDTH-1:0]; // Upper IR bits ignored

	////////////////////////////////////////////////////////////////////////////
	// Opcode to class and register operand
	////////////////////////////////////////////////////////////////////////////

	always_comb begin
		dec.cls = CL_NOP;
		dec.reg_op = REG_DI;
		case (op_code)
			OP_END:   dec.cls = CL_END;
			OP_LDAC:  dec.cls = CL_LDAC;
			OP_CLAC:  dec.cls = CL_CLAC;
			OP_INCAC: dec.cls = CL_INCAC;
			OP_DECAC: dec.cls = CL_DECAC;
			OP_MVAC_DI, OP_MVAC_RI, OP_MVAC_BI, OP_MVAC_S,
			OP_MVAC_C1, OP_MVAC_C2, OP_MVAC_AR: begin
				dec.cls = CL_MV_TO_REG;
				dec.reg_op = reg_from(op_code, OP_MVAC_DI);
			end
			OP_MV_DI, OP_MV_RI, OP_MV_BI, OP_MV_S,
			OP_MV_C1, OP_MV_C2, OP_MV_AR: begin
				dec.cls = CL_MV_FROM_REG;
				dec.reg_op = reg_from(op_code, OP_MV_DI);
			end
			OP_READ:  dec.cls = CL_READ;
			OP_WRITE: dec.cls = CL_WRITE;
			OP_ADD_DI, OP_ADD_RI, OP_ADD_BI, OP_ADD_S,
			OP_ADD_C1, OP_ADD_C2, OP_ADD_AR: begin
				dec.cls = CL_ADD;
				dec.reg_op = reg_from(op_code, OP_ADD_DI);
			end
			OP_SUB_DI, OP_SUB_RI, OP_SUB_BI, OP_SUB_S,
			OP_SUB_C1, OP_SUB_C2, OP_SUB_AR: begin
				dec.cls = CL_SUB;
				dec.reg_op = reg_from(op_code, OP_SUB_DI);
			end
			OP_MUL2:  dec.cls = CL_MUL2;
			OP_MUL4:  dec.cls = CL_MUL4;
			OP_DIV16: dec.cls = CL_DIV16;
			OP_JMPZ:  dec.cls = CL_JMPZ;
			OP_JMPNZ: dec.cls = CL_JMPNZ;
			default:  dec.cls = CL_NOP; // Unknown code runs as NOP
		endcase
	end

	////////////////////////////////////////////////////////////////////////////
	// Latch at the end of fetch
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (!reset) begin
			held.cls <= CL_NOP;
			held.reg_op <= REG_DI;
		end else if (state == ST_FETCH4) begin
			held <= dec; // IR is stable from FETCH4 on
		end
	end

	// During FETCH4 the sequencer needs the class before the latch updates
	assign instr = (state == ST_FETCH4) ? dec : held;

endmodule

// File: hw/micro_sequencer.sv
`timescale 1ns/1ps

module micro_sequencer (
	input  logic                         clk,
	input  logic                         reset,
	input  logic                         enable,
	input  logic                         z,
	input  cpu_ctrl_pkg::decoded_instr_t instr,
	output cpu_ctrl_pkg::micro_state_t   state,
	output logic                         taken
);
	import cpu_ctrl_pkg::*;

	micro_state_t next_state;
	logic         is_jump;
	logic         long_exec; // Class continues into EXEC2
	logic         jump_cond; // Branch decision for the current z

	assign is_jump = (instr.cls == CL_JMPZ) || (instr.cls == CL_JMPNZ);

	always_comb begin
		case (instr.cls)
			CL_LDAC, CL_READ, CL_WRITE, CL_JMPZ, CL_JMPNZ:
				long_exec = 1'b1;
			default:
				long_exec = 1'b0;
		endcase
	end

	// Polarity comes from the class
	always_comb begin
		case (instr.cls)
			CL_JMPZ:  jump_cond = z;
			CL_JMPNZ: jump_cond = ~z;
			default:  jump_cond = 1'b0;
		endcase
	end

	////////////////////////////////////////////////////////////////////////////
	// Next step
	////////////////////////////////////////////////////////////////////////////

	always_comb begin
		case (state)
			ST_IDLE:   next_state = ST_FETCH1;
			ST_FETCH1: next_state = ST_FETCH2;
			ST_FETCH2: next_state = ST_FETCH3;
			ST_FETCH3: next_state = ST_FETCH4;
			ST_FETCH4: begin
				case (instr.cls)
					CL_NOP:  next_state = ST_IDLE;
					CL_END:  next_state = ST_HALT;
					default: next_state = ST_EXEC1;
				endcase
			end
			ST_EXEC1: begin
				if (long_exec)
					next_state = ST_EXEC2;
				else
					next_state = ST_FETCH1;
			end
			ST_EXEC2: begin
				// Taken jump fetches the target in EXEC3 and EXEC4
				if (is_jump && taken)
					next_state = ST_EXEC3;
				else
					next_state = ST_FETCH1;
			end
			ST_EXEC3:  next_state = ST_EXEC4;
			ST_EXEC4:  next_state = ST_FETCH1;
			ST_HALT:   next_state = ST_HALT; // Left only by reset or enable low
			default:   next_state = ST_FETCH1;
		endcase
	end

	////////////////////////////////////////////////////////////////////////////
	// State and branch registers
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (!reset) begin
			state <= ST_FETCH1;
			taken <= 1'b0;
		end else if (!enable) begin
			state <= ST_IDLE; // Abort the current instruction
			taken <= 1'b0;
		end else begin
			state <= next_state;
			if (state == ST_EXEC1)
				taken <= jump_cond; // z sampled at the end of EXEC1
		end
	end

endmodule

// File: sim.f
+incdir+hw
+incdir+tb
hw/cpu_ctrl_pkg.sv
hw/instr_decode.sv
hw/micro_sequencer.sv
hw/ctrl_word_gen.sv
hw/cpu_ctrl.sv
tb/cpu_ctrl_tb.sv

// File: tb/cpu_ctrl_tb_table.svh
`ifndef CPU_CTRL_TB_TABLE_SVH
`define CPU_CTRL_TB_TABLE_SVH

	////////////////////////////////////////////////////////////////////////////
	// Opcode, z, execute steps and expected word per execute step
	////////////////////////////////////////////////////////////////////////////

	task automatic build_table();
		add_one(OP_ADD_DI, dp(ALU_ADD, BUS_DI, LOAD_NONE));
		add_one(OP_ADD_RI, dp(ALU_ADD, BUS_RI, LOAD_NONE));
		add_one(OP_ADD_BI, dp(ALU_ADD, BUS_BI, LOAD_NONE));
		add_one(OP_ADD_S, dp(ALU_ADD, BUS_S, LOAD_NONE));
		add_one(OP_ADD_C1, dp(ALU_ADD, BUS_C1, LOAD_NONE));
		add_one(OP_ADD_C2, dp(ALU_ADD, BUS_C2, LOAD_NONE));
		add_one(OP_ADD_AR, dp(ALU_ADD, BUS_AR, LOAD_NONE));
		add_one(OP_SUB_DI, dp(ALU_SUB, BUS_DI, LOAD_NONE));
		add_one(OP_SUB_RI, dp(ALU_SUB, BUS_RI, LOAD_NONE));
		add_one(OP_SUB_BI, dp(ALU_SUB, BUS_BI, LOAD_NONE));
		add_one(OP_SUB_S, dp(ALU_SUB, BUS_S, LOAD_NONE));
		add_one(OP_SUB_C1, dp(ALU_SUB, BUS_C1, LOAD_NONE));
		add_one(OP_SUB_C2, dp(ALU_SUB, BUS_C2, LOAD_NONE));
		add_one(OP_SUB_AR, dp(ALU_SUB, BUS_AR, LOAD_NONE));
		add_one(OP_MVAC_DI, dp(ALU_NOP, BUS_AC, LOAD_DI)); // Register <= AC
		add_one(OP_MVAC_RI, dp(ALU_NOP, BUS_AC, LOAD_RI));
		add_one(OP_MVAC_BI, dp(ALU_NOP, BUS_AC, LOAD_BI));
		add_one(OP_MVAC_S, dp(ALU_NOP, BUS_AC, LOAD_S));
		add_one(OP_MVAC_C1, dp(ALU_NOP, BUS_AC, LOAD_C1));
		add_one(OP_MVAC_C2, dp(ALU_NOP, BUS_AC, LOAD_C2));
		add_one(OP_MVAC_AR, dp(ALU_NOP, BUS_AC, LOAD_AR));
		add_row(8'd7, Z_RAND, 1, DEF_WORD, DEF_WORD, DEF_WORD, DEF_WORD); // Unknown code
		add_one(OP_MV_DI, dp(ALU_LOAD, BUS_DI, LOAD_NONE)); // AC <= register
		add_one(OP_MV_RI, dp(ALU_LOAD, BUS_RI, LOAD_NONE));
		add_one(OP_MV_BI, dp(ALU_LOAD, BUS_BI, LOAD_NONE));
		add_one(OP_MV_S, dp(ALU_LOAD, BUS_S, LOAD_NONE));
		add_one(OP_MV_C1, dp(ALU_LOAD, BUS_C1, LOAD_NONE));
		add_one(OP_MV_C2, dp(ALU_LOAD, BUS_C2, LOAD_NONE));
		add_one(OP_MV_AR, dp(ALU_LOAD, BUS_AR, LOAD_NONE));
		add_one(OP_CLAC, dp(ALU_CLEAR, BUS_IRAM, LOAD_NONE));
		add_one(OP_INCAC, dp(ALU_INC, BUS_IRAM, LOAD_NONE));
		add_one(OP_DECAC, dp(ALU_DEC, BUS_IRAM, LOAD_NONE));
		add_one(OP_MUL2, dp(ALU_MUL2, BUS_IRAM, LOAD_NONE));
		add_one(OP_MUL4, dp(ALU_MUL4, BUS_IRAM, LOAD_NONE));
		add_one(OP_DIV16, dp(ALU_DIV16, BUS_IRAM, LOAD_NONE));
		add_row(OP_LDAC, Z_RAND, 2, PCI_WORD, dp(ALU_LOAD, BUS_IRAM, LOAD_NONE),
			DEF_WORD, DEF_WORD);
		add_row(OP_READ, Z_RAND, 2, dp(ALU_NOP, BUS_DRAM, LOAD_NONE),
			dp(ALU_LOAD, BUS_DRAM, LOAD_NONE), DEF_WORD, DEF_WORD);
		add_row(OP_WRITE, Z_RAND, 2, '{1'b0, 1'b0, 1'b1, ALU_NOP, BUS_AC, LOAD_NONE},
			dp(ALU_NOP, BUS_DRAM, LOAD_NONE), DEF_WORD, DEF_WORD);
		// Taken jumps load PC in EXEC3
		add_row(OP_JMPZ, 2'd1, 4, PCI_WORD, DEF_WORD, dp(ALU_NOP, BUS_IRAM, LOAD_PC), DEF_WORD);
		add_row(OP_JMPZ, 2'd0, 2, PCI_WORD, DEF_WORD, DEF_WORD, DEF_WORD);
		add_row(8'd200, Z_RAND, 1, DEF_WORD, DEF_WORD, DEF_WORD, DEF_WORD);
		add_row(OP_JMPNZ, 2'd0, 4, PCI_WORD, DEF_WORD, dp(ALU_NOP, BUS_IRAM, LOAD_PC), DEF_WORD);
		add_row(OP_JMPNZ, 2'd1, 2, PCI_WORD, DEF_WORD, DEF_WORD, DEF_WORD);
	endtask

`endif

// File: tb/cpu_ctrl_tb.sv
`timescale 1ns/1ps
`include "cpu_ctrl_settings.svh"

module cpu_ctrl_tb;
	import cpu_ctrl_pkg::*;

	localparam int CLK_PERIOD = 10;
	localparam int MAX_ROWS = 48;
	localparam logic [31:0] RNG_SEED = 32'd63238;
	localparam logic [1:0] Z_RAND = 2'd2; // Row z column, random z

	// Words fixed by the fetch rules and the default word
	localparam ctrl_word_t DEF_WORD = '{1'b0, 1'b0, 1'b0, ALU_NOP, BUS_IRAM, LOAD_NONE};
	localparam ctrl_word_t LDIR_WORD = '{1'b0, 1'b0, 1'b0, ALU_NOP, BUS_IRAM, LOAD_IR};
	localparam ctrl_word_t PCI_WORD = '{1'b1, 1'b0, 1'b0, ALU_NOP, BUS_IRAM, LOAD_NONE};
	localparam ctrl_word_t FIN_WORD = '{1'b0, 1'b1, 1'b0, ALU_NOP, BUS_IRAM, LOAD_NONE};

	typedef struct packed {
		logic [`CTRL_OPCODE_WIDTH-1:0] op;
		logic [1:0]                    z;
		logic [2:0]                    n;   // Execute steps
		ctrl_word_t [3:0]              exp; // Expected word per execute step
	} row_t;

	logic                      clk;
	logic                      reset;
	logic                      enable;
	logic                      z;
	logic [`CTRL_IR_WIDTH-1:0] ir;
	ctrl_word_t                ctrl;

	row_t        table_rows [0:MAX_ROWS-1];
	int          num_rows = 0;
	logic        table_ready = 1'b0;
	logic [31:0] rng;

	cpu_ctrl UUT (
		.clk    (clk),
		.reset  (reset),
		.enable (enable),
		.z      (z),
		.ir     (ir),
		.ctrl   (ctrl)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD/2) clk = ~clk;
	end

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	function automatic ctrl_word_t dp(input alu_op_t alu, input bus_src_t bus,
		input reg_load_t ld);
		ctrl_word_t w;
		w = DEF_WORD;
		w.alu_sel = alu;
		w.bus_sel = bus;
		w.reg_sel = ld;
		return w;
	endfunction

	task automatic add_row(input logic [`CTRL_OPCODE_WIDTH-1:0] op, input logic [1:0] zv,
		input int n, input ctrl_word_t e0, input ctrl_word_t e1,
		input ctrl_word_t e2, input ctrl_word_t e3);
		row_t r;
		r.op = op;
		r.z = zv;
		r.n = n[2:0];
		r.exp[0] = e0;
		r.exp[1] = e1;
		r.exp[2] = e2;
		r.exp[3] = e3;
		table_rows[num_rows] = r;
		num_rows++;
	endtask

	// Single execute step, z is a don't care
	task automatic add_one(input logic [`CTRL_OPCODE_WIDTH-1:0] op, input ctrl_word_t e0);
		add_row(op, Z_RAND, 1, e0, DEF_WORD, DEF_WORD, DEF_WORD);
	endtask

`include "cpu_ctrl_tb_table.svh"

	////////////////////////////////////////////////////////////////////////////
	// Sampling and checks
	////////////////////////////////////////////////////////////////////////////

	// Just before the falling edge
	task automatic next_sample();
		@(posedge clk);
		#(CLK_PERIOD/2 - 1);
	endtask

	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		if (got !== exp) begin
			$display("** Error at %0d ns: %s = %0h, expected %0h", $time, name, got, exp);
			$display("CHECKS FAILED");
			$fatal(1);
		end
	endtask

	task automatic check_word(input string tag, input ctrl_word_t exp);
		check_value({"ctrl.pc_inc ", tag}, ctrl.pc_inc, exp.pc_inc);
		check_value({"ctrl.finish ", tag}, ctrl.finish, exp.finish);
		check_value({"ctrl.data_ram_we ", tag}, ctrl.data_ram_we, exp.data_ram_we);
		check_value({"ctrl.alu_sel ", tag}, ctrl.alu_sel, exp.alu_sel);
		check_value({"ctrl.bus_sel ", tag}, ctrl.bus_sel, exp.bus_sel);
		check_value({"ctrl.reg_sel ", tag}, ctrl.reg_sel, exp.reg_sel);
	endtask

	task automatic drive_ir(input logic [`CTRL_OPCODE_WIDTH-1:0] op);
		rng = xorshift32(rng);
		ir = {rng[`CTRL_IR_WIDTH-1:`CTRL_OPCODE_WIDTH], op}; // Random upper bits
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Sequences
	////////////////////////////////////////////////////////////////////////////

	// Starts on a falling edge inside FETCH1
	task automatic run_row(input row_t r);
		string tag;
		drive_ir(r.op);
		rng = xorshift32(rng);
		z = (r.z == Z_RAND) ? rng[0] : r.z[0];
		tag = $sformatf("(op %0d z %0b)", r.op, z);
		next_sample();
		check_word({"FETCH2 ", tag}, LDIR_WORD);
		next_sample();
		check_word({"FETCH3 ", tag}, PCI_WORD);
		next_sample();
		check_word({"FETCH4 ", tag}, DEF_WORD);
		for (int i = 0; i < r.n; i++) begin
			next_sample();
			check_word($sformatf("EXEC%0d %s", i + 1, tag), r.exp[i]);
		end
		next_sample();
		check_word({"FETCH1 ", tag}, DEF_WORD); // Back to fetch
		@(negedge clk);
	endtask

	task automatic halt_on_end();
		drive_ir(OP_END);
		next_sample();
		check_word("END FETCH2", LDIR_WORD);
		next_sample();
		check_word("END FETCH3", PCI_WORD);
		next_sample();
		check_word("END FETCH4", DEF_WORD);
		repeat (4) begin
			next_sample();
			check_word("HALT", FIN_WORD); // Finish stays high
		end
		@(negedge clk);
	endtask

	task automatic abort_on_enable();
		enable = 1'b0;
		next_sample();
		check_word("IDLE after HALT", DEF_WORD);
		@(negedge clk);
		enable = 1'b1;
		next_sample();
		check_word("FETCH1 after enable", DEF_WORD);
		@(negedge clk);
		drive_ir(OP_SUB_C2);
		next_sample();
		check_word("FETCH2 before abort", LDIR_WORD);
		next_sample();
		check_word("FETCH3 before abort", PCI_WORD);
		next_sample();
		check_word("FETCH4 before abort", DEF_WORD);
		@(negedge clk);
		enable = 1'b0; // Abort in place of EXEC1
		next_sample();
		check_word("IDLE on abort", DEF_WORD);
		@(negedge clk);
		enable = 1'b1;
		next_sample();
		check_word("FETCH1 on restart", DEF_WORD);
		@(negedge clk);
		run_row(table_rows[0]);
	endtask

	initial begin
		wait (table_ready);
		#((num_rows * 12 + 40) * CLK_PERIOD);
		$display("Timeout: the test sequence did not complete in time");
		$display("CHECKS FAILED");
		$fatal(1);
	end

	initial begin
		reset = 1'b0;
		enable = 1'b1;
		z = 1'b0;
		ir = '0;
		rng = RNG_SEED;
		build_table();
		table_ready = 1'b1;
		repeat (2) @(posedge clk);
		#(CLK_PERIOD/2 - 1);
		check_word("FETCH1 in reset", DEF_WORD);
		@(negedge clk);
		reset = 1'b1;
		for (int k = 0; k < num_rows; k++)
			run_row(table_rows[k]);
		halt_on_end();
		abort_on_enable();
		$display("ALL CHECKS PASSED");
		$finish;
	end

endmodule
